/* cpu_top.f */
source/cpu_pkg.sv
source/datapath_ctrl_if.sv
source/cpu_control.sv
source/accumulator_unit.sv
source/address_unit.sv
source/memory_buffer_unit.sv
source/cpu_top.sv
test/tb_memory.sv
test/tb_cpu_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the processor testbench with Verilator and run it.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cpu_top -f cpu_top.f -o tb_cpu_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_cpu_top
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

exit 0

/* test/tb_cpu_top.sv */
//##########################################################################
// Processor testbench
//##########################################################################
`timescale 1ns/100ps

module tb_cpu_top;

  localparam int MAX_INSTR        = 60;          // Longest program in instructions
  localparam int CYCLES_PER_INSTR = 30;          // Four accesses of up to six cycles, plus steps
  localparam int PROGRAM_RUNS     = 6;
  localparam int SETUP_CYCLES     = 400;         // Resets, panel loads and deposits
  localparam int TIMEOUT_CYCLES   = PROGRAM_RUNS * MAX_INSTR * CYCLES_PER_INSTR + SETUP_CYCLES;

  logic           clock = 1'b0;
  logic           resetN;
  logic           run;
  logic           deposit;
  logic           load_pc;
  cpu_pkg::word_t switches;
  cpu_pkg::word_t mem_rdata;
  logic           mem_done;
  logic           mem_read;
  logic           mem_write;
  cpu_pkg::word_t mem_addr;
  cpu_pkg::word_t mem_wdata;
  cpu_pkg::word_t ac;
  logic           link;
  logic           halt;
  cpu_pkg::word_t pc;

  cpu_pkg::word_t ref_mem [0:4095];              // Reference copy of memory
  cpu_pkg::word_t check_addrs[$];                // Words compared at halt
  cpu_pkg::word_t exp_ac;
  cpu_pkg::word_t exp_pc;
  logic           exp_link;
  cpu_pkg::word_t loop_count;                    // Negative ISZ start count
  integer         seed = 32'he2867880;
  int             cycle_count = 0;
  int             programs_checked = 0;
  int             write_starts = 0;
  logic           last_read;
  logic           last_write;
  cpu_pkg::word_t last_addr;
  cpu_pkg::word_t last_wdata;

  always #10 clock = ~clock;

  cpu_top u_dut (
    .clock     (clock),
    .resetN    (resetN),
    .run       (run),
    .deposit   (deposit),
    .load_pc   (load_pc),
    .switches  (switches),
    .mem_rdata (mem_rdata),
    .mem_done  (mem_done),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .ac        (ac),
    .link      (link),
    .halt      (halt),
    .pc        (pc)
  );

  tb_memory u_mem (
    .clock     (clock),
    .resetN    (resetN),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .mem_done  (mem_done)
  );

  task automatic check_value(input string name, input cpu_pkg::word_t actual,
                             input cpu_pkg::word_t expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
      $display("Testbench failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    $display("Testbench failed");
    $fatal(1, "Run stopped");
  endtask

  // Interprets a program from ref_mem until the halt instruction
  function automatic void ref_run(input cpu_pkg::word_t start, output cpu_pkg::word_t acc,
                                  output logic lnk, output cpu_pkg::word_t prog_ctr,
                                  output logic halted);
    cpu_pkg::word_t pc_v;
    cpu_pkg::word_t ac_v;
    cpu_pkg::word_t instr;
    cpu_pkg::word_t ea;
    cpu_pkg::word_t data;
    logic           link_v;
    logic [12:0]    sum;
    int             steps;
    pc_v   = start;
    ac_v   = '0;
    link_v = 1'b0;
    halted = 1'b0;
    steps  = 0;
    while (!halted && steps < MAX_INSTR) begin
      instr = ref_mem[pc_v];
      steps = steps + 1;
      ea    = instr[7] ? {pc_v[11:7], instr[6:0]} : {5'd0, instr[6:0]};
      if (instr[8] && instr[11:10] != 2'b11)
        ea = ref_mem[ea];                        // One level, no auto-index
      data = ref_mem[ea];
      if (instr == 12'o7402)
        halted = 1'b1;
      else begin
        case (instr[11:9])
          3'o0: begin                            // AND
            ac_v = ac_v & data;
            pc_v = pc_v + 12'd1;
          end
          3'o1: begin                            // TAD
            sum    = {1'b0, ac_v} + {1'b0, data};
            ac_v   = sum[11:0];
            link_v = link_v ^ sum[12];
            pc_v   = pc_v + 12'd1;
          end
          3'o2: begin                            // ISZ
            data        = data + 12'd1;
            ref_mem[ea] = data;
            pc_v        = pc_v + ((data == 12'd0) ? 12'd2 : 12'd1);
          end
          3'o3: begin                            // DCA
            ref_mem[ea] = ac_v;
            ac_v        = '0;
            pc_v        = pc_v + 12'd1;
          end
          3'o4: begin                            // JMS
            ref_mem[ea] = pc_v + 12'd1;
            pc_v        = ea + 12'd1;
          end
          3'o5: pc_v = ea;                       // JMP
          default: pc_v = pc_v + 12'd1;          // IOT and operate group only step
        endcase
      end
    end
    acc      = ac_v;
    lnk      = link_v;
    prog_ctr = pc_v;
  endfunction

  task automatic place(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
    ref_mem[addr] = data;
    u_mem.preload(addr, data);
  endtask

  task automatic build_program(input int prog_id, output cpu_pkg::word_t start);
    cpu_pkg::word_t a;
    for (int i = 0; i < 4096; i++) begin
      a = 12'(i);
      place(a, a ^ 12'o5252);                    // Background depends on every address bit
    end
    check_addrs.delete();
    case (prog_id)
      0: begin                                   // AND, TAD and DCA
        start = 12'o0200;
        place(12'o0200, 12'o1020);               // TAD 0020
        place(12'o0201, 12'o1270);               // TAD 0270 carries into link
        place(12'o0202, 12'o0021);               // AND 0021
        place(12'o0203, 12'o3271);               // DCA 0271
        place(12'o0204, 12'o1271);
        place(12'o0205, 12'o1022);
        place(12'o0206, 12'o3023);               // DCA 0023
        place(12'o0207, 12'o1272);
        place(12'o0210, 12'o7402);
        place(12'o0020, 12'o7000);
        place(12'o0021, 12'o0707);
        place(12'o0022, 12'o6543);
        place(12'o0270, 12'o2345);
        place(12'o0272, 12'o1234);
        check_addrs.push_back(12'o0271);
        check_addrs.push_back(12'o0023);
      end
      1: begin                                   // Indirect, JMS and JMP
        start = 12'o0400;
        place(12'o0400, 12'o1430);               // TAD I 0030
        place(12'o0401, 12'o4250);               // JMS 0450
        place(12'o0402, 12'o3431);               // DCA I 0031
        place(12'o0403, 12'o5260);               // JMP 0460
        place(12'o0451, 12'o1032);
        place(12'o0452, 12'o5650);               // JMP I 0450 returns
        place(12'o0460, 12'o1433);
        place(12'o0461, 12'o4434);               // JMS I 0034
        place(12'o0541, 12'o1340);               // TAD 0540 adds the return address
        place(12'o0542, 12'o7402);
        place(12'o0030, 12'o0500);
        place(12'o0031, 12'o0520);
        place(12'o0032, 12'o0011);
        place(12'o0033, 12'o0520);
        place(12'o0034, 12'o0540);
        place(12'o0500, 12'o0123);
        check_addrs.push_back(12'o0450);
        check_addrs.push_back(12'o0520);
        check_addrs.push_back(12'o0540);
      end
      default: begin                             // ISZ counting loop
        start = 12'o0600;
        place(12'o0600, 12'o2042);               // ISZ 0042 tallies passes
        place(12'o0601, 12'o2441);               // ISZ I 0041
        place(12'o0602, 12'o5200);               // JMP 0600
        place(12'o0603, 12'o1042);
        place(12'o0604, 12'o7402);
        place(12'o0041, 12'o0640);
        place(12'o0042, 12'o0000);
        place(12'o0640, loop_count);
        check_addrs.push_back(12'o0640);
        check_addrs.push_back(12'o0042);
      end
    endcase
  endtask

  task automatic apply_reset();
    @(negedge clock);
    resetN  = 1'b0;
    run     = 1'b0;
    deposit = 1'b0;
    load_pc = 1'b0;
    repeat (3) @(negedge clock);
    resetN = 1'b1;
  endtask

  task automatic check_reset_state();
    check_value("ac", ac, 12'd0);
    check_value("link", {11'd0, link}, 12'd0);
    check_value("pc", pc, 12'd0);
    check_value("mem_addr", mem_addr, 12'd0);
    check_value("mem_wdata", mem_wdata, 12'd0);
    check_value("mem_read", {11'd0, mem_read}, 12'd0);
    check_value("mem_write", {11'd0, mem_write}, 12'd0);
    check_value("halt", {11'd0, halt}, 12'd0);
  endtask

  // Two cycles from the sampling edge to the new pc
  task automatic panel_load_pc(input cpu_pkg::word_t value);
    @(negedge clock);
    switches = value;
    load_pc  = 1'b1;
    @(negedge clock);
    load_pc = 1'b0;
    @(negedge clock);
    check_value("pc", pc, value);
  endtask

  task automatic panel_deposit(input cpu_pkg::word_t addr, input cpu_pkg::word_t value);
    int starts;
    @(negedge clock);
    starts   = write_starts;
    switches = value;
    deposit  = 1'b1;
    @(negedge clock);
    deposit = 1'b0;
    while (!mem_write)
      @(negedge clock);
    check_value("mem_addr", mem_addr, addr);
    check_value("mem_wdata", mem_wdata, value);
    while (mem_write)
      @(negedge clock);
    check_value("pc", pc, addr + 12'd1);
    check_value("memory word", u_mem.mem[addr], value);
    check_value("writes per deposit", 12'(write_starts - starts), 12'd1);
  endtask

  task automatic run_program(input int prog_id);
    cpu_pkg::word_t start;
    logic           halted;
    int             checked_before;
    apply_reset();
    check_reset_state();
    build_program(prog_id, start);
    ref_run(start, exp_ac, exp_link, exp_pc, halted);
    if (!halted)
      report_error("reference model found no halt within the instruction limit");
    panel_load_pc(start);
    checked_before = programs_checked;
    @(negedge clock);
    run = 1'b1;
    wait (programs_checked == checked_before + 1);
    run = 1'b0;
  endtask

  // Compares the machine state with the reference at each halt
  initial begin
    forever begin
      @(negedge clock);
      if (resetN && halt) begin
        check_value("ac", ac, exp_ac);
        check_value("link", {11'd0, link}, {11'd0, exp_link});
        check_value("pc", pc, exp_pc);
        foreach (check_addrs[i])
          check_value($sformatf("mem[%0o]", check_addrs[i]), u_mem.mem[check_addrs[i]],
                      ref_mem[check_addrs[i]]);
        @(negedge clock);
        if (halt)
          report_error("halt stayed high for more than one cycle");
        programs_checked = programs_checked + 1;
      end
    end
  end

  // Memory handshake rules
  initial begin
    forever begin
      @(negedge clock);
      if (!resetN) begin
        last_read  = 1'b0;
        last_write = 1'b0;
      end
      else begin
        if (mem_read && mem_write)
          report_error("mem_read and mem_write are high together");
        if (((last_read && !mem_read) || (last_write && !mem_write)) && !mem_done)
          report_error("memory enable dropped before mem_done");
        if (mem_done && (mem_read || mem_write))
          report_error("memory enable still high in the cycle after mem_done");
        if ((last_read && mem_read) || (last_write && mem_write)) begin
          check_value("mem_addr", mem_addr, last_addr);
          check_value("mem_wdata", mem_wdata, last_wdata);
        end
        if (mem_write && !last_write)
          write_starts = write_starts + 1;
        last_read  = mem_read;
        last_write = mem_write;
        last_addr  = mem_addr;
        last_wdata = mem_wdata;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Error: run exceeded %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    cpu_pkg::word_t count_n;
    resetN   = 1'b0;
    run      = 1'b0;
    deposit  = 1'b0;
    load_pc  = 1'b0;
    switches = '0;
    apply_reset();
    check_reset_state();
    panel_load_pc(12'o0100);
    panel_deposit(12'o0100, 12'o1234);
    panel_deposit(12'o0101, 12'o5670);
    panel_deposit(12'o0102, 12'o0007);
    count_n    = 12'($unsigned($random(seed)) % 16) + 12'd1;
    loop_count = 12'd0 - count_n;
    for (int pass = 0; pass < 2; pass++) begin
      u_mem.set_random_latency(pass == 1);       // Second pass repeats with slow memory
      for (int prog = 0; prog < 3; prog++)
        run_program(prog);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

/* test/tb_memory.sv */
//##########################################################################
// Memory model with variable latency
//##########################################################################
`timescale 1ns/100ps

module tb_memory (
  input  logic           clock,
  input  logic           resetN,
  input  logic           mem_read,
  input  logic           mem_write,
  input  cpu_pkg::word_t mem_addr,
  input  cpu_pkg::word_t mem_wdata,
  output cpu_pkg::word_t mem_rdata,
  output logic           mem_done
);

  cpu_pkg::word_t mem [0:4095];
  integer         seed = 32'he2867880;
  logic           random_latency = 1'b0;         // Low answers every request in one cycle
  logic           busy;                          // A request is being served
  int             wait_left;                     // Cycles until mem_done

  initial begin
    mem_done  <= 1'b0;
    mem_rdata <= '0;
  end

  task preload(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
    mem[addr] = data;
  endtask

  task set_random_latency(input logic enable);
    random_latency = enable;
  endtask

  // Responses change on the falling edge
  always @(negedge clock or negedge resetN) begin
    if (!resetN) begin
      mem_done  <= 1'b0;
      mem_rdata <= '0;
      busy      = 1'b0;
      wait_left = 0;
    end
    else if (mem_done) begin
      mem_done <= 1'b0;                          // One-cycle pulse
      busy     = 1'b0;
    end
    else if (mem_read || mem_write) begin
      if (!busy) begin
        busy      = 1'b1;
        wait_left = random_latency ? ($unsigned($random(seed)) % 4) : 0;
      end
      else
        wait_left = wait_left - 1;
      if (wait_left == 0) begin
        if (mem_write)
          mem[mem_addr] = mem_wdata;
        mem_rdata <= mem[mem_addr];
        mem_done  <= 1'b1;
      end
    end
  end

endmodule

/* source/cpu_top.sv */
//##########################################################################
// Processor top level
//##########################################################################
`timescale 1ns/100ps

module cpu_top (
  input  logic           clock,
  input  logic           resetN,
  input  logic           run,
  input  logic           deposit,
  input  logic           load_pc,
  input  cpu_pkg::word_t switches,
  input  cpu_pkg::word_t mem_rdata,
  input  logic           mem_done,
  output logic           mem_read,
  output logic           mem_write,
  output cpu_pkg::word_t mem_addr,
  output cpu_pkg::word_t mem_wdata,
  output cpu_pkg::word_t ac,
  output logic           link,
  output logic           halt,
  output cpu_pkg::word_t pc
);

  cpu_pkg::word_t mb;                            // Memory buffer to the units

  datapath_ctrl_if ctl_if ();

  cpu_control u_control (
    .clock     (clock),
    .resetN    (resetN),
    .run       (run),
    .deposit   (deposit),
    .load_pc   (load_pc),
    .mem_done  (mem_done),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .halt      (halt),
    .ctl       (ctl_if.control)
  );

  accumulator_unit u_acc (
    .clock  (clock),
    .resetN (resetN),
    .ctl    (ctl_if.acc),
    .mb     (mb),
    .ac     (ac),
    .link   (link)
  );

  address_unit u_addr (
    .clock    (clock),
    .resetN   (resetN),
    .ctl      (ctl_if.addr),
    .ir       (ctl_if.ir),
    .mb       (mb),
    .switches (switches),
    .pc       (pc),
    .mem_addr (mem_addr)
  );

  memory_buffer_unit u_buffer (
    .clock     (clock),
    .resetN    (resetN),
    .ctl       (ctl_if.buffer),
    .mem_rdata (mem_rdata),
    .mem_done  (mem_done),
    .ac        (ac),
    .pc        (pc),
    .switches  (switches),
    .mb        (mb),
    .mem_wdata (mem_wdata)
  );

endmodule

/* source/memory_buffer_unit.sv */
//##########################################################################
// Memory buffer, instruction and write data
//##########################################################################
`timescale 1ns/100ps

module memory_buffer_unit (
  input  logic                clock,
  input  logic                resetN,
  datapath_ctrl_if.buffer     ctl,
  input  cpu_pkg::word_t      mem_rdata,
  input  logic                mem_done,
  input  cpu_pkg::word_t      ac,
  input  cpu_pkg::word_t      pc,
  input  cpu_pkg::word_t      switches,
  output cpu_pkg::word_t      mb,
  output cpu_pkg::word_t      mem_wdata
);

  cpu_pkg::word_t ir;

  assign ctl.ir      = ir;
  assign ctl.mb_zero = (mb == '0);

  always_ff @(posedge clock) begin
    if (ctl.mb_op == cpu_pkg::MB_RD && mem_done)
      mb <= mem_rdata;
    else if (ctl.mb_op == cpu_pkg::MB_INC)
      mb <= mb + 12'd1;                          // ISZ count step

    if (ctl.ir_load)
      ir <= mb;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)
      mem_wdata <= '0;
    else begin
      case (ctl.wd_sel)
        cpu_pkg::WD_AC:   mem_wdata <= ac;
        cpu_pkg::WD_MB:   mem_wdata <= mb;
        cpu_pkg::WD_PCP1: mem_wdata <= pc + 12'd1;
        cpu_pkg::WD_SW:   mem_wdata <= switches;
        default: ;
      endcase
    end
  end

endmodule

/* source/address_unit.sv */
//##########################################################################
// Program counter and address registers
//##########################################################################
`timescale 1ns/100ps

module address_unit (
  input  logic                clock,
  input  logic                resetN,
  datapath_ctrl_if.addr       ctl,
  input  cpu_pkg::word_t      ir,
  input  cpu_pkg::word_t      mb,
  input  cpu_pkg::word_t      switches,
  output cpu_pkg::word_t      pc,
  output cpu_pkg::word_t      mem_addr
);

  localparam int PAGE_W = cpu_pkg::WORD_W - cpu_pkg::PAGE_OFFSET_W;

  cpu_pkg::word_t                      ea;       // Effective address
  logic [cpu_pkg::PAGE_OFFSET_W-1:0]   offset;

  assign offset = ir[cpu_pkg::PAGE_OFFSET_W-1:0];

  always_ff @(posedge clock) begin
    unique case (ctl.ea_op)
      cpu_pkg::EA_NC: ;
      cpu_pkg::EA_PAGE0:
        ea <= {{PAGE_W{1'b0}}, offset};
      cpu_pkg::EA_CURPAGE:
        ea <= {pc[cpu_pkg::WORD_W-1:cpu_pkg::PAGE_OFFSET_W], offset};
      cpu_pkg::EA_IND:
        ea <= mb;                                // Pointer read from memory
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      pc       <= '0;
      mem_addr <= '0;
    end
    else begin
      case (ctl.pc_op)
        cpu_pkg::PC_INC:
          pc <= pc + 12'd1;
        cpu_pkg::PC_SKIP:
          pc <= pc + 12'd2;
        cpu_pkg::PC_JMP:
          pc <= ea;
        cpu_pkg::PC_SW:
          pc <= switches;
        default: ;
      endcase

      case (ctl.ad_sel)
        cpu_pkg::AD_PC:
          mem_addr <= pc;
        cpu_pkg::AD_EA:
          mem_addr <= ea;
        default: ;
      endcase
    end
  end

endmodule

/* source/accumulator_unit.sv */
//##########################################################################
// Accumulator and link
//##########################################################################
`timescale 1ns/100ps

module accumulator_unit (
  input  logic                clock,
  input  logic                resetN,
  datapath_ctrl_if.acc        ctl,
  input  cpu_pkg::word_t      mb,
  output cpu_pkg::word_t      ac,
  output logic                link
);

  cpu_pkg::word_t sum;
  logic           carry;                         // Carry out of bit 11

  assign {carry, sum} = {1'b0, ac} + {1'b0, mb};

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ac   <= '0;
      link <= 1'b0;
    end
    else begin
      unique case (ctl.ac_op)
        cpu_pkg::AC_NC: ;
        cpu_pkg::AC_AND:
          ac <= ac & mb;
        cpu_pkg::AC_TAD: begin
          ac   <= sum;
          link <= link ^ carry;                  // Carry complements link
        end
        cpu_pkg::AC_CLEAR:
          ac <= '0;
      endcase
    end
  end

endmodule

/* source/cpu_control.sv */
//##########################################################################
// Instruction sequencing FSM
//##########################################################################
`timescale 1ns/100ps

module cpu_control (
  input  logic             clock,
  input  logic             resetN,
  input  logic             run,
  input  logic             deposit,
  input  logic             load_pc,
  input  logic             mem_done,
  output logic             mem_read,
  output logic             mem_write,
  output logic             halt,
  datapath_ctrl_if.control ctl
);

  cpu_pkg::ctrl_state_e state;
  cpu_pkg::ctrl_state_e next_state;
  cpu_pkg::opcode_e     opcode;
  logic                 mem_ref;                 // Opcodes 0 to 5 address memory

  assign opcode  = cpu_pkg::opcode_e'(ctl.ir[11:9]);
  assign mem_ref = (opcode != cpu_pkg::OP_IOT) && (opcode != cpu_pkg::OP_OPR);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN)
      state <= cpu_pkg::IDLE;
    else
      state <= next_state;
  end

  // Next state and Moore outputs
  always_comb begin
    next_state  = state;
    ctl.ac_op   = cpu_pkg::AC_NC;
    ctl.pc_op   = cpu_pkg::PC_NC;
    ctl.ea_op   = cpu_pkg::EA_NC;
    ctl.ad_sel  = cpu_pkg::AD_NC;
    ctl.wd_sel  = cpu_pkg::WD_NC;
    ctl.mb_op   = cpu_pkg::MB_RD;
    ctl.ir_load = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    halt        = 1'b0;
    unique case (state)
      cpu_pkg::IDLE: begin
        if (run)
          next_state = cpu_pkg::FETCH_ADDR;
        else if (load_pc)
          next_state = cpu_pkg::LD_PC_1;
        else if (deposit)
          next_state = cpu_pkg::DEP_1;
      end
      cpu_pkg::FETCH_ADDR: begin
        ctl.ad_sel = cpu_pkg::AD_PC;
        next_state = cpu_pkg::FETCH_READ;
      end
      cpu_pkg::FETCH_READ: begin
        mem_read = 1'b1;
        if (mem_done)
          next_state = cpu_pkg::FETCH_LOAD;
      end
      cpu_pkg::FETCH_LOAD: begin
        ctl.ir_load = 1'b1;
        next_state  = cpu_pkg::CALC_EA;
      end
      cpu_pkg::CALC_EA: begin
        ctl.ea_op  = ctl.ir[7] ? cpu_pkg::EA_CURPAGE : cpu_pkg::EA_PAGE0;
        next_state = (ctl.ir[8] && mem_ref) ? cpu_pkg::IND_ADDR : cpu_pkg::DECODE;
      end
      cpu_pkg::IND_ADDR: begin
        ctl.ad_sel = cpu_pkg::AD_EA;
        next_state = cpu_pkg::IND_READ;
      end
      cpu_pkg::IND_READ: begin
        mem_read = 1'b1;                         // Pointer lands in mb
        if (mem_done)
          next_state = cpu_pkg::DECODE;
      end
      cpu_pkg::DECODE: begin
        if (ctl.ir[8] && mem_ref)
          ctl.ea_op = cpu_pkg::EA_IND;           // Pointer becomes the operand address
        if (ctl.ir == cpu_pkg::HALT_INSTR)
          next_state = cpu_pkg::HALT;
        else begin
          unique case (opcode)
            cpu_pkg::OP_AND: next_state = cpu_pkg::AND_1;
            cpu_pkg::OP_TAD: next_state = cpu_pkg::TAD_1;
            cpu_pkg::OP_ISZ: next_state = cpu_pkg::ISZ_1;
            cpu_pkg::OP_DCA: next_state = cpu_pkg::DCA_1;
            cpu_pkg::OP_JMS: next_state = cpu_pkg::JMS_1;
            cpu_pkg::OP_JMP: next_state = cpu_pkg::JMP_1;
            cpu_pkg::OP_IOT,
            cpu_pkg::OP_OPR: next_state = cpu_pkg::NOP_1;
          endcase
        end
      end
      cpu_pkg::AND_1, cpu_pkg::TAD_1, cpu_pkg::ISZ_1: begin
        ctl.ad_sel = cpu_pkg::AD_EA;
        next_state = cpu_pkg::ctrl_state_e'(state + 5'd1);
      end
      cpu_pkg::AND_2, cpu_pkg::TAD_2, cpu_pkg::ISZ_2: begin
        mem_read = 1'b1;
        if (mem_done)
          next_state = cpu_pkg::ctrl_state_e'(state + 5'd1);
      end
      cpu_pkg::AND_3: begin
        ctl.ac_op  = cpu_pkg::AC_AND;
        ctl.pc_op  = cpu_pkg::PC_INC;
        next_state = cpu_pkg::IDLE;
      end
      cpu_pkg::TAD_3: begin
        ctl.ac_op  = cpu_pkg::AC_TAD;
        ctl.pc_op  = cpu_pkg::PC_INC;
        next_state = cpu_pkg::IDLE;
      end
      cpu_pkg::ISZ_3: begin
        ctl.mb_op  = cpu_pkg::MB_INC;
        next_state = cpu_pkg::ISZ_4;
      end
      cpu_pkg::ISZ_4: begin
        ctl.mb_op  = cpu_pkg::MB_NC;
        ctl.wd_sel = cpu_pkg::WD_MB;
        next_state = cpu_pkg::ISZ_5;
      end
      cpu_pkg::ISZ_5: begin
        ctl.mb_op = cpu_pkg::MB_NC;              // Keep the count across the write
        mem_write = 1'b1;
        if (mem_done)
          next_state = cpu_pkg::ISZ_6;
      end
      cpu_pkg::ISZ_6: begin
        ctl.pc_op  = ctl.mb_zero ? cpu_pkg::PC_SKIP : cpu_pkg::PC_INC;
        next_state = cpu_pkg::IDLE;
      end
      cpu_pkg::DCA_1: begin
        ctl.ad_sel = cpu_pkg::AD_EA;
        ctl.wd_sel = cpu_pkg::WD_AC;
        next_state = cpu_pkg::DCA_2;
      end
      cpu_pkg::DCA_2: begin
        mem_write = 1'b1;
        if (mem_done)
          next_state = cpu_pkg::DCA_3;
      end
      cpu_pkg::DCA_3: begin
        ctl.ac_op  = cpu_pkg::AC_CLEAR;
        ctl.pc_op  = cpu_pkg::PC_INC;
        next_state = cpu_pkg::IDLE;
      end
      cpu_pkg::JMS_1: begin
        ctl.ad_sel = cpu_pkg::AD_EA;
        ctl.wd_sel = cpu_pkg::WD_PCP1;           // Return address
        next_state = cpu_pkg::JMS_2;
      end
      cpu_pkg::JMS_2: begin
        mem_write = 1'b1;
        ctl.pc_op = cpu_pkg::PC_JMP;
        if (mem_done)
          next_state = cpu_pkg::JMS_3;
      end
      cpu_pkg::JMS_3: begin
        ctl.pc_op  = cpu_pkg::PC_INC;            // Enter past the stored link
        next_state = cpu_pkg::IDLE;
      end
      cpu_pkg::JMP_1: begin
        ctl.pc_op  = cpu_pkg::PC_JMP;
        next_state = cpu_pkg::IDLE;
      end
      cpu_pkg::NOP_1: begin
        ctl.pc_op  = cpu_pkg::PC_INC;
        next_state = cpu_pkg::IDLE;
      end
      cpu_pkg::DEP_1: begin
        ctl.ad_sel = cpu_pkg::AD_PC;
        ctl.wd_sel = cpu_pkg::WD_SW;
        next_state = cpu_pkg::DEP_2;
      end
      cpu_pkg::DEP_2: begin
        mem_write = 1'b1;
        if (mem_done) begin
          ctl.pc_op  = cpu_pkg::PC_INC;          // Step pc on the write's last edge
          next_state = cpu_pkg::IDLE;
        end
      end
      cpu_pkg::LD_PC_1: begin
        ctl.pc_op  = cpu_pkg::PC_SW;
        next_state = cpu_pkg::IDLE;
      end
      cpu_pkg::HALT: begin
        halt       = 1'b1;
        next_state = cpu_pkg::IDLE;
      end
    endcase
  end

endmodule

/* source/datapath_ctrl_if.sv */
//##########################################################################
// Control to datapath select bundle
//##########################################################################
`timescale 1ns/100ps

interface datapath_ctrl_if;

  cpu_pkg::ac_op_e  ac_op;                       // Accumulator operation
  cpu_pkg::pc_op_e  pc_op;                       // Program counter operation
  cpu_pkg::ea_op_e  ea_op;                       // Effective address operation
  cpu_pkg::ad_sel_e ad_sel;                      // Memory address source
  cpu_pkg::wd_sel_e wd_sel;                      // Write data source
  cpu_pkg::mb_op_e  mb_op;                       // Memory buffer operation
  logic             ir_load;                     // Load ir from mb
  cpu_pkg::word_t   ir;                          // Current instruction
  logic             mb_zero;                     // mb equals zero

  modport control (
    output ac_op, pc_op, ea_op, ad_sel, wd_sel, mb_op, ir_load,
    input  ir, mb_zero
  );

  modport acc (input ac_op);

  modport addr (input pc_op, ea_op, ad_sel);

  modport buffer (
    input  wd_sel, mb_op, ir_load,
    output ir, mb_zero
  );

endinterface

/* source/cpu_pkg.sv */
//##########################################################################
// Processor shared types and constants
//##########################################################################

package cpu_pkg;

  localparam int WORD_W        = 12;             // Data and address width
  localparam int PAGE_OFFSET_W = 7;              // Offset bits within one page

  typedef logic [WORD_W-1:0] word_t;

  localparam word_t HALT_INSTR = 12'o7402;       // Operate group halt

  // Major opcode in ir[11:9]
  typedef enum logic [2:0] {
    OP_AND = 3'o0,
    OP_TAD = 3'o1,
    OP_ISZ = 3'o2,
    OP_DCA = 3'o3,
    OP_JMS = 3'o4,
    OP_JMP = 3'o5,
    OP_IOT = 3'o6,
    OP_OPR = 3'o7
  } opcode_e;

  typedef enum logic [4:0] {
    IDLE, FETCH_ADDR, FETCH_READ, FETCH_LOAD,
    CALC_EA, IND_ADDR, IND_READ, DECODE,
    AND_1, AND_2, AND_3,
    TAD_1, TAD_2, TAD_3,
    ISZ_1, ISZ_2, ISZ_3, ISZ_4, ISZ_5, ISZ_6,
    DCA_1, DCA_2, DCA_3,
    JMS_1, JMS_2, JMS_3,
    JMP_1,
    NOP_1,
    DEP_1, DEP_2, LD_PC_1,
    HALT
  } ctrl_state_e;

  typedef enum logic [1:0] {AC_NC, AC_AND, AC_TAD, AC_CLEAR} ac_op_e;

  typedef enum logic [2:0] {PC_NC, PC_INC, PC_SKIP, PC_JMP, PC_SW} pc_op_e;

  typedef enum logic [1:0] {EA_NC, EA_PAGE0, EA_CURPAGE, EA_IND} ea_op_e;

  typedef enum logic [1:0] {AD_NC, AD_PC, AD_EA} ad_sel_e;

  typedef enum logic [2:0] {WD_NC, WD_AC, WD_MB, WD_PCP1, WD_SW} wd_sel_e;

  // MB_RD captures read data only in a mem_done cycle
  typedef enum logic [1:0] {MB_RD, MB_INC, MB_NC} mb_op_e;

endpackage
